//--- dual_cam_top.f
+incdir+.
dual_cam_pkg.sv
camera_lane.sv
lane_combiner.sv
sample_fifo.sv
frame_serializer.sv
dual_cam_top.sv
tb_dual_cam_top.sv

//--- run_sim.sh
#!/bin/bash
# build and run the dual camera testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_dual_cam_top \
    -f dual_cam_top.f -o sim_dual_cam
./obj_dir/sim_dual_cam 2>&1 | tee sim.log
if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- tb_dual_cam_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "dual_cam_macros.svh"

module tb_dual_cam_top;

    //////////////////////////////////////////////////////////////////////
    // run limits and stimulus constants

    localparam int H_BLANK         = 16;
    localparam int NUM_FRAMES      = 6;
    localparam int WATCHDOG_CYCLES =
        NUM_FRAMES * (`RAW_HEIGHT + 2) * (`RAW_WIDTH + H_BLANK) + 20000;
    // host delay that lets the fifo fill up
    localparam int SLOW_ACK_DELAY  = 40;
    localparam int QUIET_CYCLES    = 200;
    localparam int FRAME_BYTES     = `MAGIC_BYTES + 2 * `ROI_WIDTH * `ROI_HEIGHT;

    // dut ports
    logic                 core_clk;
    logic                 sys_reset;
    logic                 cam0_vsync_i;
    logic                 cam0_hsync_i;
    dual_cam_pkg::pixel_t cam0_data_i;
    logic                 cam1_vsync_i;
    logic                 cam1_hsync_i;
    dual_cam_pkg::pixel_t cam1_data_i;
    dual_cam_pkg::coord_t roi_col_i;
    dual_cam_pkg::coord_t roi_row_i;
    logic                 byte_req_o;
    dual_cam_pkg::pixel_t byte_data_o;
    logic                 byte_ack_i;
    logic                 overflow_o;

    // frame images for both cameras
    dual_cam_pkg::pixel_t img0 [`RAW_HEIGHT][`RAW_WIDTH];
    dual_cam_pkg::pixel_t img1 [`RAW_HEIGHT][`RAW_WIDTH];

    // expected and captured host bytes
    dual_cam_pkg::pixel_t exp_q [$];
    dual_cam_pkg::pixel_t cap_q [$];

    logic [31:0] lcg_state = 32'hd1572a1f;
    int          ack_delay = 0;
    logic        compare_on = 1'b1;
    int          err_cnt = 0;
    int          bytes_cmp = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    dual_cam_top i_dut (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .cam0_vsync_i(cam0_vsync_i),
        .cam0_hsync_i(cam0_hsync_i),
        .cam0_data_i (cam0_data_i),
        .cam1_vsync_i(cam1_vsync_i),
        .cam1_hsync_i(cam1_hsync_i),
        .cam1_data_i (cam1_data_i),
        .roi_col_i   (roi_col_i),
        .roi_row_i   (roi_row_i),
        .byte_req_o  (byte_req_o),
        .byte_data_o (byte_data_o),
        .byte_ack_i  (byte_ack_i),
        .overflow_o  (overflow_o)
    );

    // 100 MHz
    initial begin
        core_clk = 1'b0;
        forever #5 core_clk = ~core_clk;
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // fresh random image per camera from the upper lcg bits
    task automatic fill_frame();
        int r;
        int c;
        for (r = 0; r < `RAW_HEIGHT; r++) begin
            for (c = 0; c < `RAW_WIDTH; c++) begin
                lcg_state = lcg_step(lcg_state);
                img0[r][c] = lcg_state[31:24];
                lcg_state = lcg_step(lcg_state);
                img1[r][c] = lcg_state[31:24];
            end
        end
    endtask

    // header bytes then mean and abs difference per roi pixel in raster order
    function automatic void build_expected(input int roi_c, input int roi_r);
        logic [63:0] magic;
        int          i;
        int          r;
        int          c;
        int          p0;
        int          p1;
        magic = "BIVFRAME";
        for (i = 0; i < `MAGIC_BYTES; i++) begin
            exp_q.push_back(magic[63 - 8 * i -: 8]);
        end
        for (r = 0; r < `ROI_HEIGHT; r++) begin
            for (c = 0; c < `ROI_WIDTH; c++) begin
                p0 = int'(img0[roi_r + r][roi_c + c]);
                p1 = int'(img1[roi_r + r][roi_c + c]);
                exp_q.push_back(dual_cam_pkg::pixel_t'((p0 + p1) / 2));
                exp_q.push_back(dual_cam_pkg::pixel_t'((p0 > p1) ? (p0 - p1) : (p1 - p0)));
            end
        end
    endfunction

    // one clock of camera input, both cameras in lockstep
    task automatic drive_cycle(input logic vs, input logic hs,
                               input dual_cam_pkg::pixel_t d0,
                               input dual_cam_pkg::pixel_t d1);
        @(posedge core_clk);
        #1;
        cam0_vsync_i = vs;
        cam0_hsync_i = hs;
        cam0_data_i  = d0;
        cam1_vsync_i = vs;
        cam1_hsync_i = hs;
        cam1_data_i  = d1;
    endtask

    // vsync pulse then raw lines with blanking
    task automatic drive_frame();
        int r;
        int c;
        drive_cycle(1'b1, 1'b0, 8'h00, 8'h00);
        drive_cycle(1'b1, 1'b0, 8'h00, 8'h00);
        drive_cycle(1'b0, 1'b0, 8'h00, 8'h00);
        drive_cycle(1'b0, 1'b0, 8'h00, 8'h00);
        for (r = 0; r < `RAW_HEIGHT; r++) begin
            for (c = 0; c < `RAW_WIDTH; c++) begin
                drive_cycle(1'b0, 1'b1, img0[r][c], img1[r][c]);
            end
            repeat (H_BLANK) drive_cycle(1'b0, 1'b0, 8'h00, 8'h00);
        end
    endtask

    task automatic run_frames(input int frames, input int roi_c, input int roi_r,
                              input logic expect_bytes);
        int f;
        @(posedge core_clk);
        #1;
        // roi held static across the frames
        roi_col_i = dual_cam_pkg::coord_t'(roi_c);
        roi_row_i = dual_cam_pkg::coord_t'(roi_r);
        for (f = 0; f < frames; f++) begin
            fill_frame();
            if (expect_bytes) begin
                build_expected(roi_c, roi_r);
            end
            drive_frame();
        end
    endtask

    task automatic apply_reset();
        @(posedge core_clk);
        #1;
        sys_reset = 1'b1;
        repeat (2) @(posedge core_clk);
        #1;
        sys_reset = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // checks

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got == want)
            else begin
                $display("ERROR: %s got %h expected %h", name, got, want);
                err_cnt++;
            end
    endtask

    task automatic check_byte_count(input int start, input int frames);
        int want;
        want = frames * FRAME_BYTES;
        assert (bytes_cmp - start == want)
            else begin
                $display("host received %0d bytes where %0d were expected",
                         bytes_cmp - start, want);
                err_cnt++;
            end
    endtask

    // all expected bytes seen, then a quiet stretch to catch extra bytes
    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(posedge core_clk);
        end
        repeat (QUIET_CYCLES) @(posedge core_clk);
        #1;
        check_value("byte_req_o", 32'(byte_req_o), 32'h0);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (err_cnt == err_before) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL, %0d mismatches", tests_run, name,
                     err_cnt - err_before);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // host side of the four-phase link

    initial begin
        int wait_cnt;
        wait_cnt   = 0;
        byte_ack_i = 1'b0;
        forever begin
            @(posedge core_clk);
            #1;
            if (byte_req_o && !byte_ack_i) begin
                if (wait_cnt < ack_delay) begin
                    wait_cnt++;
                end else begin
                    // data is stable while req is high
                    cap_q.push_back(byte_data_o);
                    byte_ack_i = 1'b1;
                    wait_cnt   = 0;
                end
            end else if (!byte_req_o) begin
                wait_cnt   = 0;
                byte_ack_i = 1'b0;
            end
        end
    end

    // captured bytes against the reference queue
    initial begin
        dual_cam_pkg::pixel_t got;
        dual_cam_pkg::pixel_t want;
        forever begin
            @(negedge core_clk);
            while (cap_q.size() != 0) begin
                got = cap_q.pop_front();
                if (compare_on) begin
                    assert (exp_q.size() != 0)
                        else begin
                            $display("host received extra byte %h after the frame", got);
                            err_cnt++;
                        end
                    if (exp_q.size() != 0) begin
                        want = exp_q.pop_front();
                        assert (got == want)
                            else begin
                                $display("ERROR: byte_data_o byte %0d got %h expected %h",
                                         bytes_cmp, got, want);
                                err_cnt++;
                            end
                    end
                    bytes_cmp++;
                end
            end
        end
    end

    // watchdog sized from the frame count
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge core_clk);
        $display("run stopped by the watchdog after %0d cycles, %0d bytes still missing",
                 WATCHDOG_CYCLES, exp_q.size());
        $display("Errors found");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        int err0;
        int n0;
        sys_reset    = 1'b1;
        cam0_vsync_i = 1'b0;
        cam0_hsync_i = 1'b0;
        cam0_data_i  = '0;
        cam1_vsync_i = 1'b0;
        cam1_hsync_i = 1'b0;
        cam1_data_i  = '0;
        roi_col_i    = '0;
        roi_row_i    = '0;
        repeat (2) @(posedge core_clk);
        #1;
        sys_reset = 1'b0;

        // roi at the top left corner with a fast host
        err0 = err_cnt;
        n0   = bytes_cmp;
        run_frames(1, 0, 0, 1'b1);
        wait_drained();
        check_byte_count(n0, 1);
        report_test("roi corner 0,0", err0);

        // offset window
        err0 = err_cnt;
        n0   = bytes_cmp;
        run_frames(1, 20, 30, 1'b1);
        wait_drained();
        check_byte_count(n0, 1);
        report_test("roi corner 20,30", err0);

        // two frames back to back with a header each
        err0 = err_cnt;
        n0   = bytes_cmp;
        run_frames(2, 4, 10, 1'b1);
        wait_drained();
        check_byte_count(n0, 2);
        check_value("overflow_o", 32'(overflow_o), 32'h0);
        report_test("two frames back to back", err0);

        // slow host with bytes not compared
        err0       = err_cnt;
        compare_on = 1'b0;
        ack_delay  = SLOW_ACK_DELAY;
        check_value("overflow_o", 32'(overflow_o), 32'h0);
        run_frames(1, 0, 0, 1'b0);
        check_value("overflow_o", 32'(overflow_o), 32'h1);
        repeat (QUIET_CYCLES) @(posedge core_clk);
        #1;
        // sticky
        check_value("overflow_o", 32'(overflow_o), 32'h1);
        report_test("overflow with slow host", err0);

        // reset clears the link and the flag
        err0      = err_cnt;
        ack_delay = 0;
        apply_reset();
        check_value("byte_req_o", 32'(byte_req_o), 32'h0);
        check_value("overflow_o", 32'(overflow_o), 32'h0);
        repeat (4) @(posedge core_clk);
        cap_q.delete();
        exp_q.delete();
        compare_on = 1'b1;
        n0         = bytes_cmp;
        run_frames(1, 8, 4, 1'b1);
        wait_drained();
        check_byte_count(n0, 1);
        check_value("overflow_o", 32'(overflow_o), 32'h0);
        report_test("frame after reset", err0);

        $display("tests %0d, failed %0d, bytes checked %0d, mismatches %0d",
                 tests_run, tests_failed, bytes_cmp, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dual_cam_top.sv
`default_nettype none
`timescale 1ns/10ps

module dual_cam_top (
    input  wire                  core_clk,
    input  wire                  sys_reset,
    // camera 0
    input  wire                  cam0_vsync_i,
    input  wire                  cam0_hsync_i,
    input  wire dual_cam_pkg::pixel_t cam0_data_i,
    // camera 1
    input  wire                  cam1_vsync_i,
    input  wire                  cam1_hsync_i,
    input  wire dual_cam_pkg::pixel_t cam1_data_i,
    // roi corner, held for the whole frame
    input  wire dual_cam_pkg::coord_t roi_col_i,
    input  wire dual_cam_pkg::coord_t roi_row_i,
    // host byte link
    output logic                 byte_req_o,
    output dual_cam_pkg::pixel_t byte_data_o,
    input  wire                  byte_ack_i,
    output logic                 overflow_o
);

    // lane outputs
    logic                 lane0_valid;
    dual_cam_pkg::pixel_t lane0_pix;
    logic                 lane0_sof;
    logic                 lane1_valid;
    dual_cam_pkg::pixel_t lane1_pix;
    logic                 lane1_sof;

    // combiner to fifo
    logic                 pair_valid;
    dual_cam_pkg::pair_t  pair;

    // fifo to serializer
    dual_cam_pkg::pair_t  fifo_head;
    logic                 fifo_empty;
    logic                 fifo_pop;

    //////////////////////////////////////////////////////////////////////
    // camera lanes, same roi for both

    camera_lane u_lane0 (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .vsync_i    (cam0_vsync_i),
        .hsync_i    (cam0_hsync_i),
        .data_i     (cam0_data_i),
        .roi_col_i  (roi_col_i),
        .roi_row_i  (roi_row_i),
        .pix_valid_o(lane0_valid),
        .pix_o      (lane0_pix),
        .sof_o      (lane0_sof)
    );

    camera_lane u_lane1 (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .vsync_i    (cam1_vsync_i),
        .hsync_i    (cam1_hsync_i),
        .data_i     (cam1_data_i),
        .roi_col_i  (roi_col_i),
        .roi_row_i  (roi_row_i),
        .pix_valid_o(lane1_valid),
        .pix_o      (lane1_pix),
        .sof_o      (lane1_sof)
    );

    //////////////////////////////////////////////////////////////////////
    // mean / difference pairs

    lane_combiner u_combiner (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .pix0_valid_i(lane0_valid),
        .pix0_i      (lane0_pix),
        .sof0_i      (lane0_sof),
        .pix1_valid_i(lane1_valid),
        .pix1_i      (lane1_pix),
        .sof1_i      (lane1_sof),
        .pair_valid_o(pair_valid),
        .pair_o      (pair)
    );

    //////////////////////////////////////////////////////////////////////
    // buffering and host output

    sample_fifo u_fifo (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .push_i     (pair_valid),
        .push_data_i(pair),
        .pop_i      (fifo_pop),
        .head_o     (fifo_head),
        .empty_o    (fifo_empty),
        .overflow_o (overflow_o)
    );

    frame_serializer u_serializer (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .head_i     (fifo_head),
        .empty_i    (fifo_empty),
        .pop_o      (fifo_pop),
        .byte_req_o (byte_req_o),
        .byte_data_o(byte_data_o),
        .byte_ack_i (byte_ack_i)
    );

endmodule

`default_nettype wire

//--- frame_serializer.sv
`default_nettype none
`timescale 1ns/10ps

`include "dual_cam_macros.svh"

module frame_serializer (
    input  wire                  core_clk,
    input  wire                  sys_reset,
    input  wire dual_cam_pkg::pair_t head_i,
    input  wire                  empty_i,
    output logic                 pop_o,
    output logic                 byte_req_o,
    output dual_cam_pkg::pixel_t byte_data_o,
    input  wire                  byte_ack_i
);

    localparam int HDR_W = $clog2(`MAGIC_BYTES);
    localparam logic [HDR_W-1:0] HDR_LAST = HDR_W'(`MAGIC_BYTES - 1);

    dual_cam_pkg::ser_state_t state;
    logic [HDR_W-1:0]         hdr_idx;
    // req already dropped and ack back low
    logic                     byte_done;

    // header byte idx in msb first order
    function automatic dual_cam_pkg::pixel_t magic_byte(input logic [HDR_W-1:0] idx);
        logic [8*`MAGIC_BYTES-1:0] word;
        word = `MAGIC_NUM;
        return word[8*(HDR_LAST - idx) +: 8];
    endfunction

    assign byte_done = (state != dual_cam_pkg::SER_IDLE) && !byte_req_o && !byte_ack_i;
    // entry leaves the fifo on the ack of its difference byte
    assign pop_o = (state == dual_cam_pkg::SER_DIFF) && byte_req_o && byte_ack_i;

    //////////////////////////////////////////////////////////////////////
    // fsm and four-phase req

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            state      <= dual_cam_pkg::SER_IDLE;
            hdr_idx    <= '0;
            byte_req_o <= 1'b0;
        end else begin
            if (state == dual_cam_pkg::SER_IDLE) begin
                // start only once the host has released ack
                if (!empty_i && !byte_ack_i) begin
                    byte_req_o <= 1'b1;
                    hdr_idx    <= '0;
                    state      <= head_i[16] ? dual_cam_pkg::SER_HEADER
                                             : dual_cam_pkg::SER_MEAN;
                end
            end else if (byte_req_o && byte_ack_i) begin
                // phase 3 drops req
                byte_req_o <= 1'b0;
            end else if (byte_done) begin
                case (state)
                    dual_cam_pkg::SER_HEADER: begin
                        byte_req_o <= 1'b1;
                        if (hdr_idx == HDR_LAST) begin
                            state <= dual_cam_pkg::SER_MEAN;
                        end else begin
                            hdr_idx <= hdr_idx + 1'b1;
                        end
                    end
                    dual_cam_pkg::SER_MEAN: begin
                        byte_req_o <= 1'b1;
                        state      <= dual_cam_pkg::SER_DIFF;
                    end
                    default: begin
                        // pair done so look at the next head
                        state <= dual_cam_pkg::SER_IDLE;
                    end
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // byte mux, loaded together with the rising req

    always_ff @(posedge core_clk) begin
        if (state == dual_cam_pkg::SER_IDLE) begin
            byte_data_o <= head_i[16] ? magic_byte('0) : head_i[15:8];
        end else if (byte_done) begin
            case (state)
                dual_cam_pkg::SER_HEADER: begin
                    byte_data_o <= (hdr_idx == HDR_LAST) ? head_i[15:8]
                                                         : magic_byte(hdr_idx + 1'b1);
                end
                dual_cam_pkg::SER_MEAN: byte_data_o <= head_i[7:0];
                default:                byte_data_o <= byte_data_o;
            endcase
        end
    end

    // host samples data any time while req is high
    a_data_stable: assert property (@(posedge core_clk) disable iff (sys_reset)
        $past(byte_req_o) && byte_req_o |-> $stable(byte_data_o))
        else $error("frame_serializer: byte_data_o changed under req, now %h", byte_data_o);

endmodule

`default_nettype wire

//--- sample_fifo.sv
`default_nettype none
`timescale 1ns/10ps

`include "dual_cam_macros.svh"

module sample_fifo (
    input  wire                 core_clk,
    input  wire                 sys_reset,
    input  wire                 push_i,
    input  wire dual_cam_pkg::pair_t push_data_i,
    input  wire                 pop_i,
    output dual_cam_pkg::pair_t head_o,
    output logic                empty_o,
    output logic                overflow_o
);

    dual_cam_pkg::pair_t mem [`FIFO_DEPTH];

    logic [`FIFO_ADDR_W-1:0] wr_ptr;
    logic [`FIFO_ADDR_W-1:0] rd_ptr;
    // one extra bit to tell full from empty
    logic [`FIFO_ADDR_W:0]   count;
    logic                    full;
    logic                    do_push;
    logic                    do_pop;

    assign full    = (count == (`FIFO_ADDR_W + 1)'(`FIFO_DEPTH));
    assign empty_o = (count == '0);
    // no stall upstream, so a push into a full buffer is lost
    assign do_push = push_i && !full;
    assign do_pop  = pop_i && !empty_o;

    // oldest entry, readable without a pop
    assign head_o = mem[rd_ptr];

    //////////////////////////////////////////////////////////////////////
    // storage

    always_ff @(posedge core_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // pointers, count and overflow

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // sticky until reset
            if (push_i && full) begin
                overflow_o <= 1'b1;
            end
        end
    end

    // serializer only pops an entry it has been sending
    a_no_pop_empty: assert property (@(posedge core_clk) disable iff (sys_reset)
        pop_i |-> !empty_o)
        else $error("sample_fifo: pop while empty");

endmodule

`default_nettype wire

//--- lane_combiner.sv
`default_nettype none
`timescale 1ns/10ps

module lane_combiner (
    input  wire                  core_clk,
    input  wire                  sys_reset,
    input  wire                  pix0_valid_i,
    input  wire dual_cam_pkg::pixel_t pix0_i,
    input  wire                  sof0_i,
    input  wire                  pix1_valid_i,
    input  wire dual_cam_pkg::pixel_t pix1_i,
    input  wire                  sof1_i,
    output logic                 pair_valid_o,
    output dual_cam_pkg::pair_t  pair_o
);

    // 9-bit sum so the carry is kept
    logic [8:0]           sum;
    dual_cam_pkg::pixel_t mean;
    dual_cam_pkg::pixel_t diff;

    //////////////////////////////////////////////////////////////////////
    // pair arithmetic

    assign sum  = {1'b0, pix0_i} + {1'b0, pix1_i};
    // floor of the average
    assign mean = sum[8:1];
    // absolute difference, subtract the smaller one
    assign diff = (pix0_i >= pix1_i) ? (pix0_i - pix1_i) : (pix1_i - pix0_i);

    //////////////////////////////////////////////////////////////////////
    // output register

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            pair_valid_o <= 1'b0;
        end else begin
            pair_valid_o <= pix0_valid_i && pix1_valid_i;
        end
    end

    // frame start follows lane 0
    always_ff @(posedge core_clk) begin
        if (pix0_valid_i) begin
            pair_o <= {sof0_i, mean, diff};
        end
    end

    // both lanes see the same sync timing and the same roi corner
    a_lanes_lockstep: assert property (@(posedge core_clk) disable iff (sys_reset)
        (pix0_valid_i == pix1_valid_i) && (!pix0_valid_i || (sof0_i == sof1_i)))
        else $error("lane_combiner: lanes out of step valid=%b/%b sof=%b/%b",
                    pix0_valid_i, pix1_valid_i, sof0_i, sof1_i);

endmodule

`default_nettype wire

//--- camera_lane.sv
`default_nettype none
`timescale 1ns/10ps

`include "dual_cam_macros.svh"

module camera_lane (
    input  wire                  core_clk,
    input  wire                  sys_reset,
    input  wire                  vsync_i,
    input  wire                  hsync_i,
    input  wire dual_cam_pkg::pixel_t data_i,
    input  wire dual_cam_pkg::coord_t roi_col_i,
    input  wire dual_cam_pkg::coord_t roi_row_i,
    output logic                 pix_valid_o,
    output dual_cam_pkg::pixel_t pix_o,
    output logic                 sof_o
);

    // position of the pixel on data_i this cycle
    dual_cam_pkg::coord_t col;
    dual_cam_pkg::coord_t row;
    // offset from the roi corner
    dual_cam_pkg::coord_t col_off;
    dual_cam_pkg::coord_t row_off;

    logic vsync_q;
    logic hsync_q;
    logic vsync_rise;
    logic hsync_fall;
    logic in_roi;

    //////////////////////////////////////////////////////////////////////
    // sync edge detect

    assign vsync_rise = vsync_i && !vsync_q;
    assign hsync_fall = !hsync_i && hsync_q;

    //////////////////////////////////////////////////////////////////////
    // row / column tracking

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            vsync_q <= 1'b0;
            hsync_q <= 1'b0;
            col     <= '0;
            row     <= '0;
        end else begin
            vsync_q <= vsync_i;
            hsync_q <= hsync_i;
            if (vsync_rise) begin
                // new frame starts at the top left
                col <= '0;
                row <= '0;
            end else if (hsync_fall) begin
                // end of line
                col <= '0;
                row <= row + 1'b1;
            end else if (hsync_i) begin
                col <= col + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // roi window

    // wraps below the corner, so the >= check keeps those out
    assign col_off = col - roi_col_i;
    assign row_off = row - roi_row_i;
    assign in_roi  = (col >= roi_col_i) && (col_off < dual_cam_pkg::coord_t'(`ROI_WIDTH)) &&
                     (row >= roi_row_i) && (row_off < dual_cam_pkg::coord_t'(`ROI_HEIGHT));

    // flags
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            pix_valid_o <= 1'b0;
            sof_o       <= 1'b0;
        end else begin
            pix_valid_o <= hsync_i && in_roi;
            // first roi pixel of the frame
            sof_o       <= hsync_i && in_roi && (col_off == '0) && (row_off == '0);
        end
    end

    // pixel data
    always_ff @(posedge core_clk) begin
        if (hsync_i) begin
            pix_o <= data_i;
        end
    end

    // camera must not send more pixels than the raw frame holds
    a_pix_in_frame: assert property (@(posedge core_clk) disable iff (sys_reset)
        hsync_i |-> (col < dual_cam_pkg::coord_t'(`RAW_WIDTH)) &&
                    (row < dual_cam_pkg::coord_t'(`RAW_HEIGHT)))
        else $error("camera_lane: pixel outside raw frame col=%0d row=%0d", col, row);

endmodule

`default_nettype wire

//--- dual_cam_pkg.sv
`default_nettype none

package dual_cam_pkg;

    //////////////////////////////////////////////////////////////////////
    // stream data types

    // one 8-bit camera sample
    typedef logic [7:0] pixel_t;

    // row or column index inside the raw frame
    typedef logic [9:0] coord_t;

    // combined entry
    // [16] start of frame, [15:8] mean, [7:0] abs difference
    typedef logic [16:0] pair_t;

    //////////////////////////////////////////////////////////////////////
    // serializer fsm

    typedef enum logic [1:0] {
        SER_IDLE,   // waiting for a fifo entry
        SER_HEADER, // magic bytes before the first pair of a frame
        SER_MEAN,   // mean byte of the head pair
        SER_DIFF    // difference byte, entry popped on its ack
    } ser_state_t;

endpackage

`default_nettype wire

//--- dual_cam_macros.svh
`ifndef DUAL_CAM_MACROS_SVH
`define DUAL_CAM_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// frame geometry

// raw camera frame, pixels per line and lines per frame
`define RAW_WIDTH 64
`define RAW_HEIGHT 48

// cropped window sent to the host
`define ROI_WIDTH 16
`define ROI_HEIGHT 8

//////////////////////////////////////////////////////////////////////
// pair buffer

`define FIFO_DEPTH 64
// log2 of FIFO_DEPTH
`define FIFO_ADDR_W 6

//////////////////////////////////////////////////////////////////////
// host framing

// "BIVFRAME" in ascii, sent msb first
`define MAGIC_NUM 64'h42_49_56_46_52_41_4D_45
`define MAGIC_BYTES 8

`endif
